/* hdl/udp_tx_pkg.sv */
`default_nettype none

package udp_tx_pkg;

    // addresses, ports and payload length of one burst
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] data_len;
    } udp_cfg_t;

    typedef enum logic [7:0] {
        IDLE  = 8'h00,
        DONE  = 8'h02,
        FILL  = 8'h13,
        SEND0 = 8'h20,
        GAP0  = 8'h21,
        SEND1 = 8'h22,
        GAP1  = 8'h23,
        SEND2 = 8'h24,
        GAP2  = 8'h25,
        SEND3 = 8'h26,
        GAP3  = 8'h27
    } ctrl_state_t;

    // TX_IDLE keeps the name apart from the burst state IDLE
    typedef enum logic [2:0] {
        TX_IDLE,
        MAC_HDR,
        IP_HDR,
        UDP_HDR,
        PAYLOAD
    } tx_field_t;

    localparam int FRAMES_PER_BURST = 4;
    localparam int GAP_CYCLES       = 12;
    localparam int GAP_CNT_W        = $clog2(GAP_CYCLES + 1);

    localparam int MAC_HDR_BYTES = 14;
    localparam int IP_HDR_BYTES  = 20;
    localparam int UDP_HDR_BYTES = 8;
    localparam int HDR_BYTES     = MAC_HDR_BYTES + IP_HDR_BYTES + UDP_HDR_BYTES; // 42

    localparam int MAX_DATA_LEN = 60;
    localparam int PAY_CNT_W    = $clog2(MAX_DATA_LEN + 1);
    localparam int FIFO_DEPTH   = 256;  // room for a whole burst of 4 x 60 bytes
    localparam int FIFO_AW      = $clog2(FIFO_DEPTH);

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL     = 8'h45;  // version 4, five header words
    localparam logic [7:0]  IP_PROTO_UDP   = 8'h11;
    localparam logic [7:0]  IP_TTL         = 8'h40;
    localparam logic [15:0] IP_FLAGS_DF    = 16'h4000;

endpackage

`default_nettype wire

/* hdl/burst_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module burst_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       fill_fd,
    input  logic       send_fd,
    input  logic       gap_fd,
    output logic       fill_fs,
    output logic       send_fs,
    output logic       gap_fs,
    output logic [1:0] frame_idx,
    output logic       busy,
    output logic       done
);
    import udp_tx_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            gap_fs <= 1'b0;
        end else begin
            state  <= state_nxt;
            gap_fs <= send_fs && send_fd;  // high in the first cycle of each gap
        end
    end

    // start is only looked at in IDLE, so a start during a burst is dropped
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start) state_nxt = FILL;
            FILL:    if (fill_fd) state_nxt = SEND0;
            SEND0:   if (send_fd) state_nxt = GAP0;
            GAP0:    if (gap_fd) state_nxt = SEND1;
            SEND1:   if (send_fd) state_nxt = GAP1;
            GAP1:    if (gap_fd) state_nxt = SEND2;
            SEND2:   if (send_fd) state_nxt = GAP2;
            GAP2:    if (gap_fd) state_nxt = SEND3;
            SEND3:   if (send_fd) state_nxt = GAP3;
            GAP3:    if (gap_fd) state_nxt = DONE;
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_comb begin
        case (state)
            SEND1, GAP1: frame_idx = 2'd1;
            SEND2, GAP2: frame_idx = 2'd2;
            SEND3, GAP3: frame_idx = 2'd3;
            default:     frame_idx = 2'd0;
        endcase
    end

    assign fill_fs = (state == FILL);
    assign send_fs = (state == SEND0) || (state == SEND1) ||
                     (state == SEND2) || (state == SEND3);
    assign busy    = (state != IDLE);  // drops as DONE is left, together with done
    assign done    = (state == DONE);

endmodule

`default_nettype wire

/* hdl/gap_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module gap_timer (
    input  logic clk,
    input  logic rst,
    input  logic gap_fs,
    output logic gap_fd
);
    import udp_tx_pkg::*;

    logic [GAP_CNT_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            gap_fd <= 1'b0;
        end else begin
            gap_fd <= 1'b0;
            if (gap_fs) begin
                cnt <= GAP_CNT_W'(GAP_CYCLES);
            end else if (cnt != '0) begin
                cnt    <= cnt - 1'b1;
                gap_fd <= (cnt == GAP_CNT_W'(1));  // last step of the count
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/payload_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module payload_gen (
    input  logic        clk,
    input  logic        rst,
    input  logic        fill_fs,
    input  logic [7:0]  seed,
    input  logic [15:0] data_len,
    input  logic        full,
    output logic        wr_en,
    output logic [7:0]  din,
    output logic        fill_fd
);
    import udp_tx_pkg::*;

    logic        fill_fs_q;
    logic        active;
    logic [15:0] remain;
    logic        fill_start;

    assign fill_start = fill_fs && !fill_fs_q;
    assign wr_en      = active && !full && (remain != '0);
    assign fill_fd    = active && (remain == '0);  // one cycle, active clears right after

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_fs_q <= 1'b0;
            active    <= 1'b0;
            remain    <= '0;
        end else begin
            fill_fs_q <= fill_fs;
            if (fill_start) begin
                active <= 1'b1;
                remain <= 16'(data_len * FRAMES_PER_BURST);  // payload of all four frames
            end else if (fill_fd) begin
                active <= 1'b0;
            end else if (wr_en) begin
                remain <= remain - 1'b1;
            end
        end
    end

    // the byte value runs on across frame boundaries
    always_ff @(posedge clk) begin
        if (fill_start) begin
            din <= seed;
        end else if (wr_en) begin
            din <= din + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/byte_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module byte_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_en,
    input  logic [7:0] din,
    input  logic       rd_en,
    output logic [7:0] dout,
    output logic       full,
    output logic       empty
);
    import udp_tx_pkg::*;

    logic [7:0]       mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        // read data shows up one cycle after rd_en
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* hdl/udp_frame_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module udp_frame_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 send_fs,
    input  udp_tx_pkg::udp_cfg_t cfg,
    input  logic [7:0]           dout,
    output logic                 rd_en,
    output logic [7:0]           txd,
    output logic                 txen,
    output logic                 send_fd
);
    import udp_tx_pkg::*;

    tx_field_t              state;
    udp_cfg_t               cfg_q;
    logic                   send_fs_q;
    logic                   send_start;
    logic [5:0]             byte_cnt;  // position inside the 42 header bytes
    logic [PAY_CNT_W-1:0]   pay_cnt;   // payload bytes still to go, the current one included
    logic [15:0]            ip_id;
    logic [15:0]            csum_q;
    logic [15:0]            ip_len;
    logic [15:0]            udp_len;
    logic                   hdr_done;
    logic [HDR_BYTES*8-1:0] hdr;

    function automatic logic [15:0] ip_checksum(input udp_cfg_t c, input logic [15:0] len,
                                                input logic [15:0] id);
        logic [19:0] sum;
        logic [16:0] fold;
        sum = {IP_VER_IHL, 8'h00} + len + id + IP_FLAGS_DF + {IP_TTL, IP_PROTO_UDP} +
              c.src_ip[31:16] + c.src_ip[15:0] + c.dst_ip[31:16] + c.dst_ip[15:0];
        fold = sum[15:0] + sum[19:16];
        return ~(fold[15:0] + fold[16]);  // second carry cannot overflow again
    endfunction

    assign send_start = send_fs && !send_fs_q;
    assign ip_len     = cfg_q.data_len + 16'(IP_HDR_BYTES + UDP_HDR_BYTES);
    assign udp_len    = cfg_q.data_len + 16'(UDP_HDR_BYTES);
    assign hdr_done   = (state == UDP_HDR) && (byte_cnt == 6'(HDR_BYTES - 1));

    // UDP checksum goes out as zero
    assign hdr = {cfg_q.dst_mac, cfg_q.src_mac, ETHERTYPE_IPV4,
                  IP_VER_IHL, 8'h00, ip_len, ip_id, IP_FLAGS_DF,
                  IP_TTL, IP_PROTO_UDP, csum_q, cfg_q.src_ip, cfg_q.dst_ip,
                  cfg_q.src_port, cfg_q.dst_port, udp_len, 16'h0000};

    // first read goes out with the last header byte so payload follows without a hole
    assign rd_en = hdr_done || ((state == PAYLOAD) && (pay_cnt > PAY_CNT_W'(1)));
    assign txen  = (state != TX_IDLE);
    assign txd   = !txen ? 8'h00 :
                   (state == PAYLOAD) ? dout : hdr[(HDR_BYTES - 1 - byte_cnt) * 8 +: 8];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= TX_IDLE;
            send_fs_q <= 1'b0;
            send_fd   <= 1'b0;
            byte_cnt  <= '0;
            pay_cnt   <= '0;
            ip_id     <= '0;
        end else begin
            send_fs_q <= send_fs;
            send_fd   <= 1'b0;
            case (state)
                TX_IDLE: begin
                    byte_cnt <= '0;
                    if (send_start) state <= MAC_HDR;
                end
                MAC_HDR: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 6'(MAC_HDR_BYTES - 1)) state <= IP_HDR;
                end
                IP_HDR: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 6'(MAC_HDR_BYTES + IP_HDR_BYTES - 1)) state <= UDP_HDR;
                end
                UDP_HDR: begin
                    if (hdr_done) begin
                        state    <= PAYLOAD;
                        byte_cnt <= '0;
                        pay_cnt  <= cfg_q.data_len[PAY_CNT_W-1:0];
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                PAYLOAD: begin
                    pay_cnt <= pay_cnt - 1'b1;
                    if (pay_cnt == PAY_CNT_W'(1)) begin
                        state   <= TX_IDLE;
                        send_fd <= 1'b1;
                        ip_id   <= ip_id + 1'b1;  // next frame gets the next id
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == TX_IDLE) && send_start) begin
            cfg_q <= cfg;
        end
        if ((state == MAC_HDR) && (byte_cnt == '0)) begin
            csum_q <= ip_checksum(cfg_q, ip_len, ip_id);  // needed from IP byte 10 on
        end
    end

endmodule

`default_nettype wire

/* hdl/udp_tx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module udp_tx_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  udp_tx_pkg::udp_cfg_t cfg,
    input  logic [7:0]           seed,
    output logic [7:0]           txd,
    output logic                 txen,
    output logic                 busy,
    output logic                 done
);

    logic       fill_fs;
    logic       fill_fd;
    logic       send_fs;
    logic       send_fd;
    logic       gap_fs;
    logic       gap_fd;
    logic       wr_en;
    logic       rd_en;
    logic       full;
    logic [7:0] din;
    logic [7:0] dout;

    burst_ctrl i_burst_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .fill_fd   (fill_fd),
        .send_fd   (send_fd),
        .gap_fd    (gap_fd),
        .fill_fs   (fill_fs),
        .send_fs   (send_fs),
        .gap_fs    (gap_fs),
        .frame_idx (),
        .busy      (busy),
        .done      (done)
    );

    gap_timer i_gap_timer (
        .clk    (clk),
        .rst    (rst),
        .gap_fs (gap_fs),
        .gap_fd (gap_fd)
    );

    payload_gen i_payload_gen (
        .clk      (clk),
        .rst      (rst),
        .fill_fs  (fill_fs),
        .seed     (seed),
        .data_len (cfg.data_len),
        .full     (full),
        .wr_en    (wr_en),
        .din      (din),
        .fill_fd  (fill_fd)
    );

    // reads are never issued past the fill, so empty stays inside the FIFO
    byte_fifo i_byte_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr_en (wr_en),
        .din   (din),
        .rd_en (rd_en),
        .dout  (dout),
        .full  (full),
        .empty ()
    );

    udp_frame_tx i_udp_frame_tx (
        .clk     (clk),
        .rst     (rst),
        .send_fs (send_fs),
        .cfg     (cfg),
        .dout    (dout),
        .rd_en   (rd_en),
        .txd     (txd),
        .txen    (txen),
        .send_fd (send_fd)
    );

endmodule

`default_nettype wire

/* tests/udp_tx_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module udp_tx_checker (
    input logic clk,
    input logic rst,
    input logic send_fs,
    input logic send_fd,
    input logic txen,
    input logic rd_en,
    input logic empty,
    input logic wr_en,
    input logic full
);

    int fail_cnt = 0;

    txen_inside_send: assert property (@(posedge clk) disable iff (rst) txen |-> send_fs)
        else begin
            fail_cnt++;
            $error("txen is high while send_fs is low");
        end

    no_read_when_empty: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
        else begin
            fail_cnt++;
            $error("rd_en is high while the FIFO is empty");
        end

    no_write_when_full: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
        else begin
            fail_cnt++;
            $error("wr_en is high while the FIFO is full");
        end

    send_fd_single: assert property (@(posedge clk) disable iff (rst) send_fd |=> !send_fd)
        else begin
            fail_cnt++;
            $error("send_fd is longer than one cycle");
        end

endmodule

// the top level sees the serializer strobes and, one level down, the FIFO's empty flag
bind udp_tx_top udp_tx_checker i_checker (
    .clk     (clk),
    .rst     (rst),
    .send_fs (send_fs),
    .send_fd (send_fd),
    .txen    (txen),
    .rd_en   (rd_en),
    .empty   (i_byte_fifo.empty),
    .wr_en   (wr_en),
    .full    (full)
);

`default_nettype wire

/* tests/tb_udp_tx.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_udp_tx;
    import udp_tx_pkg::*;

    localparam int DONE_TIMEOUT = 2000;  // longest burst is well under 800 cycles

    logic       clk;
    logic       rst;
    logic       start;
    udp_cfg_t   cfg;
    logic [7:0] seed;
    logic [7:0] txd;
    logic       txen;
    logic       busy;
    logic       done;

    logic [7:0]  rx_bytes[$];
    logic [7:0]  exp_bytes[$];
    logic [15:0] gold_csum[FRAMES_PER_BURST];
    int          cur_len;
    logic [7:0]  cur_seed;
    int          burst_frames;
    int          frames_total;
    int          done_cnt;
    int          idle_cnt;
    logic        txen_q;

    udp_tx_top i_dut (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .cfg   (cfg),
        .seed  (seed),
        .txd   (txd),
        .txen  (txen),
        .busy  (busy),
        .done  (done)
    );

    always #5 clk = ~clk;

    task automatic stop_with_fail();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first failed check");
    endtask

    task automatic check_equal(input string name, input int exp, input int act);
        assert (exp == act) else begin
            $display("** Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
            stop_with_fail();
        end
    endtask

    task automatic check_gap(input string name);
        assert (idle_cnt >= GAP_CYCLES) else begin
            $display("** Error: %s expected >= %0d actual %0d", name, GAP_CYCLES, idle_cnt);
            stop_with_fail();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        stop_with_fail();
    endtask

    // appends the n low bytes of v, most significant first
    task automatic push_field(input logic [47:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            exp_bytes.push_back(v[i*8 +: 8]);
        end
    endtask

    function automatic logic [15:0] header_checksum(input logic [15:0] tot_len,
                                                    input logic [15:0] id);
        logic [15:0] words[10];
        logic [31:0] sum;
        // version/ihl, length, id, DF flag, ttl/protocol, zero checksum, addresses
        words = '{16'h4500, tot_len, id, 16'h4000, 16'h4011, 16'h0000,
                  cfg.src_ip[31:16], cfg.src_ip[15:0], cfg.dst_ip[31:16], cfg.dst_ip[15:0]};
        sum = '0;
        foreach (words[i]) begin
            sum += words[i];
        end
        while (sum[31:16] != 0) begin
            sum = sum[15:0] + sum[31:16];  // end-around carry
        end
        return ~sum[15:0];
    endfunction

    task automatic check_frame();
        logic [15:0] tot_len;
        logic [15:0] id;
        logic [15:0] own_csum;
        string       field;
        tot_len  = 16'(28 + cur_len);
        id       = 16'(frames_total);  // ids count every frame since reset
        own_csum = header_checksum(tot_len, id);
        assert (burst_frames < FRAMES_PER_BURST) else begin
            $display("more than four frames were sent in one burst");
            stop_with_fail();
        end
        check_equal("ones' complement model vs golden checksum", gold_csum[burst_frames],
                    own_csum);
        exp_bytes.delete();
        push_field(cfg.dst_mac, 6);
        push_field(cfg.src_mac, 6);
        push_field(48'h0800, 2);
        push_field(48'h4500, 2);
        push_field(tot_len, 2);
        push_field(id, 2);
        push_field(48'h4000_4011, 4);  // DF, ttl 64 and protocol udp
        push_field(gold_csum[burst_frames], 2);
        push_field(cfg.src_ip, 4);
        push_field(cfg.dst_ip, 4);
        push_field(cfg.src_port, 2);
        push_field(cfg.dst_port, 2);
        push_field(48'(8 + cur_len), 2);
        push_field(48'h0, 2);
        for (int k = 0; k < cur_len; k++) begin
            exp_bytes.push_back(8'(cur_seed + burst_frames * cur_len + k));
        end
        check_equal("frame length", exp_bytes.size(), rx_bytes.size());
        for (int i = 0; i < rx_bytes.size(); i++) begin
            if (i < 14) field = "mac header";
            else if (i < 34) field = "ip header";
            else if (i < HDR_BYTES) field = "udp header";
            else field = "payload";
            check_equal($sformatf("%s byte %0d of frame %0d", field, i, frames_total),
                        exp_bytes[i], rx_bytes[i]);
        end
        rx_bytes.delete();
        burst_frames++;
        frames_total++;
    endtask

    // collects each frame while txen is high and checks it when txen drops
    always @(negedge clk) begin
        if (!rst) begin
            if (txen) begin
                if (!txen_q && frames_total > 0) begin
                    check_gap("idle cycles before a frame");
                end
                rx_bytes.push_back(txd);
                idle_cnt = 0;
            end else begin
                if (txen_q) begin
                    check_frame();
                end
                idle_cnt++;
            end
            if (done) begin
                done_cnt++;
                check_equal("frames before done", FRAMES_PER_BURST, burst_frames);
                check_gap("idle cycles after the last frame");
            end
            txen_q = txen;
        end
    end

    initial begin
        int    fd;
        int    n;
        int    nb;
        int    idle;
        int    cyc;
        int    len;
        int    sd;
        int    c[FRAMES_PER_BURST];
        string line;
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        seed         = '0;
        cfg          = '{dst_mac: 48'h02005e100001, src_mac: 48'h02005e100002,
                         src_ip: 32'hc0a8010a, dst_ip: 32'hc0a80114,
                         src_port: 16'd5000, dst_port: 16'd6000, data_len: 16'd0};
        txen_q       = 1'b0;
        burst_frames = 0;
        frames_total = 0;
        done_cnt     = 0;
        idle_cnt     = 0;
        nb           = 0;
        void'($urandom(32'h35b3c833));
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        repeat (8) begin
            @(posedge clk);
            #1;
            check_equal("txen before start", 0, txen);
            check_equal("busy before start", 0, busy);
            check_equal("done before start", 0, done);
        end
        fd = $fopen("tests/udp_tx_golden.txt", "r");
        assert (fd != 0) else begin
            $display("the golden file tests/udp_tx_golden.txt could not be opened");
            stop_with_fail();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %h %h %h %h %h", len, sd, c[0], c[1], c[2], c[3]);
            assert (n == 6) else begin
                $display("a line of the golden file does not hold six values");
                stop_with_fail();
            end
            idle = $urandom_range(20, 0);
            repeat (idle) @(posedge clk);
            @(posedge clk);
            #1;
            check_equal("busy between bursts", 0, busy);
            cur_len  = len;
            cur_seed = 8'(sd);
            foreach (c[i]) begin
                gold_csum[i] = 16'(c[i]);
            end
            burst_frames = 0;
            cfg.data_len = 16'(len);
            seed         = 8'(sd);
            start        = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
            check_equal("busy after start", 1, busy);
            cyc = 0;
            while (!done) begin
                @(posedge clk);
                #1;
                cyc++;
                start = (nb % 2 == 1) && (cyc == 9);  // odd bursts get a start while busy
                assert (cyc < DONE_TIMEOUT) else report_timeout("the done pulse of a burst");
            end
            @(posedge clk);
            #1;
            check_equal("busy after done", 0, busy);
            check_equal("done pulse width", 0, done);
            nb++;
            check_equal("done pulses so far", nb, done_cnt);
        end
        $fclose(fd);
        assert (nb > 0) else begin
            $display("the golden file holds no burst");
            stop_with_fail();
        end
        repeat (40) @(posedge clk);
        #1;
        check_equal("frames in total", FRAMES_PER_BURST * nb, frames_total);
        check_equal("done pulses in total", nb, done_cnt);
        if (i_dut.i_checker.fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/udp_tx_golden.txt */
# data_len (decimal), payload seed (hex), expected IPv4 checksums of frames 0 to 3 (hex)
# the IP id runs on across bursts, so every burst uses the next four ids
1  00 b761 b760 b75f b75e
60 ff b722 b721 b720 b71f
17 5a b749 b748 b747 b746
32 80 b736 b735 b734 b733
2  c3 b750 b74f b74e b74d
45 10 b721 b720 b71f b71e
8  7f b742 b741 b740 b73f
59 e0 b70b b70a b709 b708
13 01 b735 b734 b733 b732
50 99 b70c b70b b70a b709
3  fe b737 b736 b735 b734
27 3c b71b b71a b719 b718
60 a5 b6f6 b6f5 b6f4 b6f3
1  42 b72d b72c b72b b72a
40 d7 b702 b701 b700 b6ff
21 66 b711 b710 b70f b70e

/* list.f */
hdl/udp_tx_pkg.sv
hdl/burst_ctrl.sv
hdl/gap_timer.sv
hdl/payload_gen.sv
hdl/byte_fifo.sv
hdl/udp_frame_tx.sv
hdl/udp_tx_top.sv
tests/udp_tx_checker.sv
tests/tb_udp_tx.sv

/* Bender.yml */
package:
  name: udp_tx

sources:
  - hdl/udp_tx_pkg.sv
  - hdl/burst_ctrl.sv
  - hdl/gap_timer.sv
  - hdl/payload_gen.sv
  - hdl/byte_fifo.sv
  - hdl/udp_frame_tx.sv
  - hdl/udp_tx_top.sv
  - target: test
    files:
      - tests/udp_tx_checker.sv
      - tests/tb_udp_tx.sv
